// File: list.f
+incdir+rtl
rtl/gol_pkg.sv
rtl/host_reg_capture.sv
rtl/generation_sequencer.sv
rtl/life_board.sv
rtl/gol_persona.sv
verif/gol_clk_gen.sv
verif/gol_tb.sv

// File: Makefile
# Verilator flow for the life persona and its directed testbench
# Override any variable on the command line, for example make sim TOP=gol_tb

VERILATOR ?= verilator
FILELIST  ?= list.f
TOP       ?= gol_tb
RTL_TOP   ?= gol_persona
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_TEXT)"; then \
	   echo "Simulation passed"; \
	else \
	   echo "Simulation failed"; \
	   exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

// File: verif/gol_tb.sv
// Directed testbench for the life persona
// Acts as the static-region host bridge and checks every board against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "gol_defs.svh"

module gol_tb;

   localparam int          SIDE          = `GOL_BOARD_SIDE;
   localparam int          BUSY_WAIT_MAX = 20;
   localparam logic [31:0] DONE_SLACK    = 32'd50;
   localparam int          CLEAR_WAIT_MAX = 20;

   logic               clk;
   logic               pr_logic_rst;
   logic [31:0]        host_cntrl_register;
   gol_pkg::reg_file_t host_pr;
   logic               clr_io_reg;
   logic [31:0]        persona_id;
   gol_pkg::reg_file_t pr_host;

   int          err_count;
   int unsigned seed_draw;

   gol_clk_gen u_gol_clk_gen (
      .clk (clk)
   );

   gol_persona u_gol_persona (
      .clk                 (clk),
      .pr_logic_rst        (pr_logic_rst),
      .host_cntrl_register (host_cntrl_register),
      .host_pr             (host_pr),
      .clr_io_reg          (clr_io_reg),
      .persona_id          (persona_id),
      .pr_host             (pr_host)
   );

   // A cell off the board reads as dead
   function automatic logic cell_alive(input gol_pkg::board_t b, input int r, input int c);
      if (r < 0 || r >= SIDE || c < 0 || c >= SIDE) begin
         return 1'b0;
      end
      return b[r*SIDE+c];
   endfunction

   // Reference model for one generation of the life rule
   function automatic gol_pkg::board_t model_step(input gol_pkg::board_t b);
      gol_pkg::board_t nb;
      int              n;
      nb = '0;
      for (int r = 0; r < SIDE; r++) begin
         for (int c = 0; c < SIDE; c++) begin
            n = int'(cell_alive(b, r - 1, c - 1)) + int'(cell_alive(b, r - 1, c)) +
                int'(cell_alive(b, r - 1, c + 1)) + int'(cell_alive(b, r, c - 1)) +
                int'(cell_alive(b, r, c + 1)) + int'(cell_alive(b, r + 1, c - 1)) +
                int'(cell_alive(b, r + 1, c)) + int'(cell_alive(b, r + 1, c + 1));
            // Three neighbours always give a live cell, two only keep one alive
            if (n == 3) begin
               nb[r*SIDE+c] = 1'b1;
            end else if (n == 2) begin
               nb[r*SIDE+c] = b[r*SIDE+c];
            end
         end
      end
      return nb;
   endfunction

   // Reference result after a whole run of gens generations
   function automatic gol_pkg::board_t model_run(input gol_pkg::board_t b, input int gens);
      gol_pkg::board_t cur;
      cur = b;
      for (int i = 0; i < gens; i++) begin
         cur = model_step(cur);
      end
      return cur;
   endfunction

   // Board with one more live cell at row r, column c
   function automatic gol_pkg::board_t place(input gol_pkg::board_t b, input int r, input int c);
      return b | (64'd1 << (r*SIDE+c));
   endfunction

   // Advance to just after the next rising edge where outputs are settled
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "stopped at time %0t", $time);
   endtask

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp) begin
         err_count++;
         $display("mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
         fail_run("first error reached");
      end
   endtask

   task automatic wait_busy();
      int n;
      n = 0;
      while (pr_host[0][0] !== 1'b1) begin
         if (n >= BUSY_WAIT_MAX) begin
            fail_run("timed out waiting for the busy flag");
         end
         tick();
         n++;
      end
   endtask

   task automatic wait_done(input logic [31:0] max_cycles);
      logic [31:0] n;
      n = '0;
      while (pr_host[0][1] !== 1'b1) begin
         if (n >= max_cycles) begin
            fail_run("timed out waiting for the done flag");
         end
         tick();
         n++;
      end
   endtask

   // Load a limit and a board, pulse start and wait for the run to finish
   task automatic run_life(input logic [31:0] limit, input gol_pkg::board_t start,
                           output gol_pkg::board_t final_b);
      tick();
      host_pr    = '0;
      host_pr[0] = limit;
      host_pr[1] = start[63:32];
      host_pr[2] = start[31:0];
      host_cntrl_register[1] = 1'b1;
      tick();
      host_cntrl_register[1] = 1'b0;
      // A previous run may still show done, so see busy first
      wait_busy();
      wait_done(limit + DONE_SLACK);
      final_b = {pr_host[1], pr_host[2]};
      check_value(64'(pr_host[0]), 64'd2, "status word after run");
   endtask

   task automatic test_reset();
      check_value(64'(persona_id), 64'(`GOL_PERSONA_ID), "persona id");
      check_value(64'(pr_host[0]), 64'd0, "status word after reset");
      check_value({pr_host[1], pr_host[2]}, 64'd0, "board after reset");
      check_value(64'(clr_io_reg), 64'd0, "clr_io_reg after reset");
      // Words above the board carry nothing and read zero
      for (int w = 3; w < `GOL_REG_FILE_IO_SIZE; w++) begin
         check_value(64'(pr_host[w]), 64'd0, $sformatf("unused word %0d after reset", w));
      end
   endtask

   task automatic test_oscillators();
      gol_pkg::board_t horiz;
      gol_pkg::board_t vert;
      gol_pkg::board_t block;
      gol_pkg::board_t got;
      horiz = place(place(place('0, 3, 2), 3, 3), 3, 4);
      vert  = place(place(place('0, 2, 3), 3, 3), 4, 3);
      block = place(place(place(place('0, 1, 1), 1, 2), 2, 1), 2, 2);
      run_life(32'd1, horiz, got);
      check_value(got, model_run(horiz, 1), "blinker after 1 generation vs model");
      check_value(got, vert, "blinker vertical after 1 generation");
      run_life(32'd2, horiz, got);
      check_value(got, model_run(horiz, 2), "blinker after 2 generations vs model");
      check_value(got, horiz, "blinker horizontal after 2 generations");
      run_life(32'd5, block, got);
      check_value(got, block, "block after 5 generations");
   endtask

   task automatic test_zero_limit();
      gol_pkg::board_t start;
      gol_pkg::board_t got;
      start = 64'h0123_4567_89AB_CDEF;
      run_life(32'd0, start, got);
      check_value(got, start, "board with a limit of 0");
   endtask

   task automatic test_random_boards();
      gol_pkg::board_t start;
      gol_pkg::board_t got;
      logic [31:0]     limit;
      for (int i = 0; i < 10; i++) begin
         start = {$urandom, $urandom};
         limit = $urandom % 21;
         run_life(limit, start, got);
         check_value(got, model_run(start, int'(limit)), $sformatf("random board %0d", i));
      end
   endtask

   task automatic test_clear_mid_run();
      gol_pkg::board_t start;
      gol_pkg::board_t got;
      int              n;
      int              width;
      start = {$urandom, $urandom};
      tick();
      host_pr    = '0;
      host_pr[0] = 32'd1000;
      host_pr[1] = start[63:32];
      host_pr[2] = start[31:0];
      host_cntrl_register[1] = 1'b1;
      tick();
      host_cntrl_register[1] = 1'b0;
      wait_busy();
      // Let the run get well under way before the clear lands
      for (int i = 0; i < 5; i++) begin
         tick();
      end
      host_cntrl_register[0] = 1'b1;
      n = 0;
      while (clr_io_reg !== 1'b1) begin
         if (n >= CLEAR_WAIT_MAX) begin
            fail_run("timed out waiting for the clr_io_reg pulse");
         end
         tick();
         n++;
      end
      // The bridge wipes its registers on clr_io_reg
      host_pr = '0;
      host_cntrl_register[0] = 1'b0;
      width = 0;
      while (clr_io_reg === 1'b1 && width < CLEAR_WAIT_MAX) begin
         width++;
         tick();
      end
      check_value(64'(width), 64'd1, "clr_io_reg pulse width");
      // Sequencer goes idle one edge after the pulse and the board clears one edge later
      tick();
      tick();
      check_value(64'(pr_host[0]), 64'd0, "status word after clear");
      check_value(64'(pr_host[1]), 64'd0, "board word 1 after clear");
      check_value(64'(pr_host[2]), 64'd0, "board word 2 after clear");
      start = {$urandom, $urandom};
      run_life(32'd7, start, got);
      check_value(got, model_run(start, 7), "run after clear vs model");
   endtask

   initial begin
      err_count           = 0;
      seed_draw           = $urandom(32'h651a);
      pr_logic_rst        = 1'b1;
      host_cntrl_register = '0;
      host_pr             = '0;
      repeat (4) @(posedge clk);
      #1;
      pr_logic_rst = 1'b0;
      tick();
      test_reset();
      test_oscillators();
      test_zero_limit();
      test_random_boards();
      test_clear_mid_run();
      if (err_count == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         fail_run("errors were counted during the run");
      end
   end

endmodule

`default_nettype wire

// File: verif/gol_clk_gen.sv
// Clock source for the life persona testbench
// Produces a free-running clock with a 4 ns period
`timescale 1ns/1ps
`default_nettype none

module gol_clk_gen (
   output logic clk
);

   // Start low so the first rising edge lands at 2 ns
   initial begin
      clk = 1'b0;
   end

   always #2 clk = ~clk;

endmodule

`default_nettype wire

// File: rtl/gol_persona.sv
// Top level of the life persona
// Connects the capture, sequencer and board stages to the host register
// bank and packs the status and board words the host reads back
`timescale 1ns/1ps
`default_nettype none

`include "gol_defs.svh"

module gol_persona (
   input  wire                     clk,
   input  wire                     pr_logic_rst,
   input  wire [31:0]              host_cntrl_register,
   input  wire gol_pkg::reg_file_t host_pr,
   output logic                    clr_io_reg,
   output logic [31:0]             persona_id,
   output gol_pkg::reg_file_t      pr_host
);

   gol_pkg::host_cmd_t  cmd;
   gol_pkg::step_ctrl_t ctrl;
   gol_pkg::board_t     board;
   logic                busy;
   logic                done;

   // Stage 1 captures host control edges and payload
   host_reg_capture u_host_reg_capture (
      .clk                 (clk),
      .pr_logic_rst        (pr_logic_rst),
      .host_cntrl_register (host_cntrl_register),
      .host_pr             (host_pr),
      .cmd                 (cmd)
   );

   // Stage 2 sequences the generations of a run
   generation_sequencer u_generation_sequencer (
      .clk          (clk),
      .pr_logic_rst (pr_logic_rst),
      .cmd          (cmd),
      .ctrl         (ctrl),
      .busy         (busy),
      .done         (done)
   );

   // Stage 3 holds the board and computes generations
   life_board u_life_board (
      .clk          (clk),
      .pr_logic_rst (pr_logic_rst),
      .ctrl         (ctrl),
      .board_start  (cmd.board_start),
      .board        (board)
   );

   // The clear pulse also tells the static region to wipe its registers
   assign clr_io_reg = cmd.clear;
   assign persona_id = `GOL_PERSONA_ID;

   // Word 0 is status, words 1 and 2 are the board, the rest read zero
   always_comb begin
      pr_host    = '0;
      pr_host[0] = {30'd0, done, busy};
      pr_host[1] = board[63:32];
      pr_host[2] = board[31:0];
   end

endmodule

`default_nettype wire

// File: rtl/life_board.sv
// Board engine of the life persona
// Holds the 64 cells and computes the next generation on each step strobe
// Cells beyond the edges count as dead so the board does not wrap
`timescale 1ns/1ps
`default_nettype none

`include "gol_defs.svh"

module life_board (
   input  wire                      clk,
   input  wire                      pr_logic_rst,
   input  wire gol_pkg::step_ctrl_t ctrl,
   input  wire gol_pkg::board_t     board_start,
   output gol_pkg::board_t          board
);

   localparam int SIDE = `GOL_BOARD_SIDE;

   // Current generation
   gol_pkg::board_t board_q;
   // Generation that follows board_q
   gol_pkg::board_t board_next;

   // Apply the life rule to every cell of a board
   function automatic gol_pkg::board_t life_next(input gol_pkg::board_t cur);
      gol_pkg::board_t nxt;
      int              live;
      int              rr;
      int              cc;
      nxt = '0;
      for (int r = 0; r < SIDE; r++) begin
         for (int c = 0; c < SIDE; c++) begin
            // Count the live cells among the eight neighbours
            live = 0;
            for (int dr = -1; dr <= 1; dr++) begin
               for (int dc = -1; dc <= 1; dc++) begin
                  rr = r + dr;
                  cc = c + dc;
                  // Skip the cell itself and anything off the board
                  if (!(dr == 0 && dc == 0) &&
                      rr >= 0 && rr < SIDE && cc >= 0 && cc < SIDE) begin
                     if (cur[rr*SIDE+cc]) begin
                        live++;
                     end
                  end
               end
            end
            // Birth with three neighbours
            // Survival with two or three
            nxt[r*SIDE+c] = (live == 3) || (live == 2 && cur[r*SIDE+c]);
         end
      end
      return nxt;
   endfunction

   assign board_next = life_next(board_q);

   // Clear has priority over a load, and a load over a step
   // The sequencer raises at most one of these strobes in any cycle
   always_ff @(posedge clk) begin
      if (pr_logic_rst) begin
         board_q <= '0;
      end else if (ctrl.clear) begin
         board_q <= '0;
      end else if (ctrl.init) begin
         board_q <= board_start;
      end else if (ctrl.step) begin
         board_q <= board_next;
      end
   end

   assign board = board_q;

endmodule

`default_nettype wire

// File: rtl/generation_sequencer.sv
// Generation sequencer of the life persona
// Runs an FSM that loads the board on start and then issues one step per
// cycle until the generation limit is reached
`timescale 1ns/1ps
`default_nettype none

module generation_sequencer (
   input  wire                    clk,
   input  wire                    pr_logic_rst,
   input  wire gol_pkg::host_cmd_t cmd,
   output gol_pkg::step_ctrl_t    ctrl,
   output logic                   busy,
   output logic                   done
);

   // Current run state
   gol_pkg::run_state_e state_q;

   // Generations computed so far in this run
   logic [31:0] gen_count_q;

   // One-cycle load and clear strobes for the board engine
   logic init_q;
   logic clear_q;

   // Combinational step strobe
   logic step;

   // Steps are issued while running and below the limit
   // The load cycle is skipped so the starting board is in place first
   assign step = (state_q == gol_pkg::RUNNING) && !init_q &&
                 (gen_count_q < cmd.gen_limit);

   always_ff @(posedge clk) begin
      if (pr_logic_rst) begin
         state_q     <= gol_pkg::IDLE;
         gen_count_q <= '0;
         init_q      <= 1'b0;
         clear_q     <= 1'b0;
      end else begin
         // Strobes drop after one cycle unless set again below
         init_q  <= 1'b0;
         clear_q <= 1'b0;
         if (cmd.clear) begin
            // Clear wins over start and abandons any run
            state_q     <= gol_pkg::IDLE;
            gen_count_q <= '0;
            clear_q     <= 1'b1;
         end else if (cmd.start) begin
            // Start from any state restarts the run with a fresh load
            state_q     <= gol_pkg::RUNNING;
            gen_count_q <= '0;
            init_q      <= 1'b1;
         end else if (step) begin
            gen_count_q <= gen_count_q + 32'd1;
         end else if (state_q == gol_pkg::RUNNING && !init_q) begin
            // Limit reached and the last generation is already registered
            state_q <= gol_pkg::DONE;
         end
      end
   end

   // Controls for the board engine
   always_comb begin
      ctrl.init  = init_q;
      ctrl.step  = step;
      ctrl.clear = clear_q;
   end

   // Status flags decoded from the state
   assign busy = (state_q == gol_pkg::RUNNING);
   assign done = (state_q == gol_pkg::DONE);

endmodule

`default_nettype wire

// File: rtl/host_reg_capture.sv
// Host capture stage of the life persona
// Turns the clear and start control bits into one-cycle pulses and
// latches the generation limit and the starting board from the host words
`timescale 1ns/1ps
`default_nettype none

module host_reg_capture (
   input  wire                     clk,
   input  wire                     pr_logic_rst,
   input  wire [31:0]              host_cntrl_register,
   input  wire gol_pkg::reg_file_t host_pr,
   output gol_pkg::host_cmd_t      cmd
);

   // First sample of the control bits
   // Bit 0 is clear and bit 1 is start
   logic [1:0] cntrl_q;
   // Second sample which serves as the previous value for edge detection
   logic [1:0] cntrl_prev_q;

   // Registered rising-edge pulses
   logic clear_q;
   logic start_q;

   // Latched copies of the host payload words
   logic [31:0]      limit_q;
   gol_pkg::board_t  board_q;

   // Sample the control bits twice so that a new level seen at one edge
   // produces its pulse at the following edge
   always_ff @(posedge clk) begin
      if (pr_logic_rst) begin
         cntrl_q      <= 2'b00;
         cntrl_prev_q <= 2'b00;
      end else begin
         cntrl_q      <= host_cntrl_register[1:0];
         cntrl_prev_q <= cntrl_q;
      end
   end

   // A pulse is high for exactly one cycle after each 0 to 1 change
   always_ff @(posedge clk) begin
      if (pr_logic_rst) begin
         clear_q <= 1'b0;
         start_q <= 1'b0;
      end else begin
         clear_q <= cntrl_q[0] & ~cntrl_prev_q[0];
         start_q <= cntrl_q[1] & ~cntrl_prev_q[1];
      end
   end

   // The payload follows the host words with one cycle of delay
   // A clear pulse wipes the latched limit and board
   always_ff @(posedge clk) begin
      if (clear_q) begin
         limit_q <= '0;
         board_q <= '0;
      end else begin
         limit_q <= host_pr[0];
         // Word 1 holds the upper half of the board and word 2 the lower half
         board_q <= {host_pr[1], host_pr[2]};
      end
   end

   // Pack the pulses and payload for the sequencer
   always_comb begin
      cmd.clear       = clear_q;
      cmd.start       = start_q;
      cmd.gen_limit   = limit_q;
      cmd.board_start = board_q;
   end

endmodule

`default_nettype wire

// File: rtl/gol_pkg.sv
// Types shared by the stages of the life persona
// Refer to them with scoped names such as gol_pkg::board_t
`default_nettype none

`include "gol_defs.svh"

package gol_pkg;

   // Host register bank with word 0 in the lowest 32 bits
   typedef logic [`GOL_REG_FILE_IO_SIZE-1:0][31:0] reg_file_t;

   // Board with the cell of row r and column c at bit r*8+c
   typedef logic [`GOL_BOARD_SIDE*`GOL_BOARD_SIDE-1:0] board_t;

   // Commands and payload captured from the host, 98 bits in all
   typedef struct packed {
      logic        clear;
      logic        start;
      logic [31:0] gen_limit;
      board_t      board_start;
   } host_cmd_t;

   // Controls from the sequencer to the board engine
   typedef struct packed {
      logic init;
      logic step;
      logic clear;
   } step_ctrl_t;

   // States of a generation run
   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      RUNNING = 2'd1,
      DONE    = 2'd2
   } run_state_e;

endpackage

`default_nettype wire

// File: rtl/gol_defs.svh
// Sizes and constants shared by the life persona RTL and its testbench
// Include this header wherever one of the macros below is needed

`ifndef GOL_DEFS_SVH
`define GOL_DEFS_SVH

// Number of 32-bit words in each direction of the host register bank
`define GOL_REG_FILE_IO_SIZE 8

// Side length of the square board in cells
`define GOL_BOARD_SIDE 8

// Identifier the persona reports to the static region
// It spells "gol" in ASCII
`define GOL_PERSONA_ID 32'h00676F6C

`endif
